//--- rtl/armPkg.sv
// ARM core shared definitions
`default_nettype none

package armPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 4;
	localparam logic [regAddrWidth-1:0] pcRegIndex = 4'd15;

	// Instruction classes from bits 27:26
	localparam logic [1:0] opDataProc = 2'b00;
	localparam logic [1:0] opMemory = 2'b01;
	localparam logic [1:0] opBranch = 2'b10;

	// ALU operation codes
	localparam logic [2:0] aluAdd = 3'b000;
	localparam logic [2:0] aluSub = 3'b001;
	localparam logic [2:0] aluAnd = 3'b010;
	localparam logic [2:0] aluOrr = 3'b011;
	localparam logic [2:0] aluEor = 3'b100;

	typedef enum logic [3:0] {
		fetch,
		decode,
		memAdr,
		memRead,
		memWriteback,
		memWrite,
		executeReg,
		executeImm,
		aluWriteback,
		branch
	} fsmState_t;

	typedef struct packed {
		logic negative;
		logic zero;
		logic carry;
		logic overflow;
	} aluFlags_t;

	// Per-state controls from the main FSM
	typedef struct packed {
		logic nextPc;
		logic branch;
		logic memW;
		logic regW;
		logic irWrite;
		logic adrSrc;
		logic [1:0] resultSrc;
		logic [1:0] aluSrcA;
		logic [1:0] aluSrcB;
		logic aluOp;
	} fsmCtrl_t;

	typedef struct packed {
		logic [1:0] regSrc;
		logic [1:0] immSrc;
		logic [2:0] aluControl;
	} decodeCtrl_t;

	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] op;
		logic imm;
		logic [3:0] cmd;
		logic s;
		logic [3:0] rn;
		logic [3:0] rd;
		logic [11:0] operand2;
	} dpFormat_t;

	// Flags hold I P U B W L with the load bit last
	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] op;
		logic [5:0] flags;
		logic [3:0] rn;
		logic [3:0] rd;
		logic [11:0] offset12;
	} memFormat_t;

	typedef struct packed {
		logic [3:0] cond;
		logic [1:0] op;
		logic [1:0] fixed;
		logic [23:0] offset24;
	} brFormat_t;

	typedef union packed {
		dpFormat_t dp;
		memFormat_t mem;
		brFormat_t br;
	} instrWord_t;

endpackage

`default_nettype wire

//--- rtl/alu.sv
// Arithmetic logic unit
`timescale 1ns/1ps
`default_nettype none

module alu import armPkg::*; (
	input wire [dataWidth-1:0] a,
	input wire [dataWidth-1:0] b,
	input wire [2:0] aluControl,
	output logic [dataWidth-1:0] result,
	output aluFlags_t flags
);

	logic [dataWidth-1:0] condInvB;
	logic [dataWidth:0] sum;
	logic isSub;
	logic isArith;

	assign isSub = (aluControl == aluSub);
	assign isArith = (aluControl == aluAdd) || isSub;

	// Subtract as a + ~b + 1, carry out means no borrow
	assign condInvB = isSub ? ~b : b;
	assign sum = a + condInvB + {{dataWidth{1'b0}}, isSub};

	always_comb begin
		case (aluControl)
			aluAnd: result = a & b;
			aluOrr: result = a | b;
			aluEor: result = a ^ b;
			default: result = sum[dataWidth-1:0];
		endcase
	end

	assign flags.negative = result[dataWidth-1];
	assign flags.zero = (result == '0);
	assign flags.carry = isArith & sum[dataWidth];
	// Operands agree in sign after inversion and the sum disagrees
	assign flags.overflow = isArith & ~(a[dataWidth-1] ^ condInvB[dataWidth-1]) &
		(a[dataWidth-1] ^ sum[dataWidth-1]);

endmodule

`default_nettype wire

//--- rtl/regFile.sv
// Register file
`timescale 1ns/1ps
`default_nettype none

module regFile import armPkg::*; (
	input wire clk,
	input wire we,
	input wire [regAddrWidth-1:0] ra1,
	input wire [regAddrWidth-1:0] ra2,
	input wire [regAddrWidth-1:0] wa,
	input wire [dataWidth-1:0] wd,
	input wire [dataWidth-1:0] r15,
	output logic [dataWidth-1:0] rd1,
	output logic [dataWidth-1:0] rd2
);

	// R0 to R14, the PC lives in the datapath
	logic [dataWidth-1:0] regs [pcRegIndex];

	always_ff @(posedge clk) begin
		if (we && (wa != pcRegIndex)) begin
			regs[wa] <= wd;
		end
	end

	assign rd1 = (ra1 == pcRegIndex) ? r15 : regs[ra1];
	assign rd2 = (ra2 == pcRegIndex) ? r15 : regs[ra2];

endmodule

`default_nettype wire

//--- rtl/datapath.sv
// Multicycle datapath
`timescale 1ns/1ps
`default_nettype none

module datapath import armPkg::*; (
	input wire clk,
	input wire reset,
	input wire fsmCtrl_t ctrl,
	input wire decodeCtrl_t dec,
	input wire pcWrite,
	input wire regWrite,
	input wire [dataWidth-1:0] memReadData,
	output logic [dataWidth-1:0] memAdr,
	output logic [dataWidth-1:0] memWriteData,
	output instrWord_t instr,
	output aluFlags_t aluFlags
);

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] data;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] writeData;
	logic [dataWidth-1:0] aluOut;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] result;
	logic [dataWidth-1:0] extImm;
	logic [dataWidth-1:0] srcA;
	logic [dataWidth-1:0] srcB;
	logic [dataWidth-1:0] rd1;
	logic [dataWidth-1:0] rd2;
	logic [regAddrWidth-1:0] ra1;
	logic [regAddrWidth-1:0] ra2;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (pcWrite) begin
			pc <= result;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			instr <= '0;
		end else if (ctrl.irWrite) begin
			instr <= memReadData;
		end
	end

	// Staging registers load every cycle
	always_ff @(posedge clk) begin
		data <= memReadData;
		opA <= rd1;
		writeData <= rd2;
		aluOut <= aluResult;
	end

	assign memAdr = ctrl.adrSrc ? result : pc;
	assign memWriteData = writeData;

	assign ra1 = dec.regSrc[0] ? pcRegIndex : instr.dp.rn;
	assign ra2 = dec.regSrc[1] ? instr.dp.rd : instr.dp.operand2[3:0];

	regFile u_regFile (
		.clk(clk),
		.we(regWrite),
		.ra1(ra1),
		.ra2(ra2),
		.wa(instr.dp.rd),
		.wd(result),
		.r15(result),
		.rd1(rd1),
		.rd2(rd2)
	);

	always_comb begin
		case (dec.immSrc)
			2'b00: extImm = {24'b0, instr.dp.operand2[7:0]};
			2'b01: extImm = {20'b0, instr.mem.offset12};
			2'b10: extImm = {{6{instr.br.offset24[23]}}, instr.br.offset24, 2'b00};
			default: extImm = '0;
		endcase
	end

	always_comb begin
		case (ctrl.aluSrcA)
			2'b00: srcA = opA;
			2'b01: srcA = pc;
			default: srcA = aluOut;
		endcase
		case (ctrl.aluSrcB)
			2'b00: srcB = writeData;
			2'b01: srcB = extImm;
			default: srcB = 32'd4;
		endcase
		case (ctrl.resultSrc)
			2'b00: result = aluOut;
			2'b01: result = data;
			default: result = aluResult;
		endcase
	end

	alu u_alu (
		.a(srcA),
		.b(srcB),
		.aluControl(dec.aluControl),
		.result(aluResult),
		.flags(aluFlags)
	);

endmodule

`default_nettype wire

//--- rtl/condUnit.sv
// Flags and conditional execution
`timescale 1ns/1ps
`default_nettype none

module condUnit import armPkg::*; (
	input wire clk,
	input wire reset,
	input wire instrWord_t instr,
	input wire aluFlags_t aluFlags,
	input wire [1:0] flagW,
	input wire pcs,
	input wire fsmCtrl_t ctrl,
	output logic pcWrite,
	output logic regWrite,
	output logic memWrite
);

	aluFlags_t flags;
	logic [1:0] flagWrite;
	logic condEx;
	logic condExReg;
	logic ge;

	assign flagWrite = flagW & {2{condEx}};

	// N and Z
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flags.negative <= 1'b0;
			flags.zero <= 1'b0;
		end else if (flagWrite[1]) begin
			flags.negative <= aluFlags.negative;
			flags.zero <= aluFlags.zero;
		end
	end

	// C and V
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flags.carry <= 1'b0;
			flags.overflow <= 1'b0;
		end else if (flagWrite[0]) begin
			flags.carry <= aluFlags.carry;
			flags.overflow <= aluFlags.overflow;
		end
	end

	assign ge = (flags.negative == flags.overflow);

	always_comb begin
		case (instr.dp.cond)
			4'b0000: condEx = flags.zero;
			4'b0001: condEx = ~flags.zero;
			4'b0010: condEx = flags.carry;
			4'b0011: condEx = ~flags.carry;
			4'b0100: condEx = flags.negative;
			4'b0101: condEx = ~flags.negative;
			4'b0110: condEx = flags.overflow;
			4'b0111: condEx = ~flags.overflow;
			4'b1000: condEx = flags.carry & ~flags.zero;
			4'b1001: condEx = ~(flags.carry & ~flags.zero);
			4'b1010: condEx = ge;
			4'b1011: condEx = ~ge;
			4'b1100: condEx = ~flags.zero & ge;
			4'b1101: condEx = ~(~flags.zero & ge);
			default: condEx = 1'b1;
		endcase
	end

	// Flags only move in execute, so this holds the decode-time result
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			condExReg <= 1'b0;
		end else begin
			condExReg <= condEx;
		end
	end

	assign regWrite = ctrl.regW & condExReg;
	assign memWrite = ctrl.memW & condExReg;
	assign pcWrite = (pcs & condExReg) | ctrl.nextPc;

endmodule

`default_nettype wire

//--- rtl/instrDecode.sv
// Instruction and ALU decoder
`timescale 1ns/1ps
`default_nettype none

module instrDecode import armPkg::*; (
	input wire instrWord_t instr,
	input wire fsmCtrl_t ctrl,
	output decodeCtrl_t dec,
	output logic [1:0] flagW,
	output logic pcs
);

	always_comb begin
		dec.aluControl = aluAdd;
		flagW = 2'b00;
		if (ctrl.aluOp) begin
			case (instr.dp.cmd)
				4'b0100: dec.aluControl = aluAdd;
				4'b0010: dec.aluControl = aluSub;
				4'b0000: dec.aluControl = aluAnd;
				4'b1100: dec.aluControl = aluOrr;
				4'b0001: dec.aluControl = aluEor;
				default: dec.aluControl = aluAdd;
			endcase
			// Upper pair is N and Z, lower pair C and V only for arithmetic
			flagW[1] = instr.dp.s;
			flagW[0] = instr.dp.s &
				((dec.aluControl == aluAdd) || (dec.aluControl == aluSub));
		end

		// Extension format follows the instruction class
		case (instr.dp.op)
			opDataProc: dec.immSrc = 2'b00;
			opMemory: dec.immSrc = 2'b01;
			opBranch: dec.immSrc = 2'b10;
			default: dec.immSrc = 2'b00;
		endcase

		// Bit 1 reads rd for a store, bit 0 reads R15 for a branch
		dec.regSrc[1] = (instr.dp.op == opMemory);
		dec.regSrc[0] = (instr.dp.op == opBranch);
	end

	// Any write to R15 redirects the PC
	assign pcs = ctrl.branch | (ctrl.regW & (instr.dp.rd == pcRegIndex));

endmodule

`default_nettype wire

//--- rtl/controlFsm.sv
// Main control state machine
`timescale 1ns/1ps
`default_nettype none

module controlFsm import armPkg::*; (
	input wire clk,
	input wire reset,
	input wire instrWord_t instr,
	output fsmCtrl_t ctrl
);

	fsmState_t state;
	fsmState_t nextState;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			fetch: nextState = decode;
			decode: begin
				case (instr.dp.op)
					opDataProc: nextState = instr.dp.imm ? executeImm : executeReg;
					opMemory: nextState = memAdr;
					opBranch: nextState = branch;
					default: nextState = fetch;
				endcase
			end
			// Load bit picks the read or write path
			memAdr: nextState = instr.mem.flags[0] ? memRead : memWrite;
			memRead: nextState = memWriteback;
			executeReg, executeImm: nextState = aluWriteback;
			default: nextState = fetch;
		endcase
	end

	// Source selects: A is 00 reg, 01 PC, 10 ALU out; B is 00 reg, 01 imm, 10 four
	always_comb begin
		ctrl = '0;
		case (state)
			fetch: begin
				// PC + 4 goes back to the PC while the IR loads
				ctrl.nextPc = 1'b1;
				ctrl.irWrite = 1'b1;
				ctrl.resultSrc = 2'b10;
				ctrl.aluSrcA = 2'b01;
				ctrl.aluSrcB = 2'b10;
			end
			decode: begin
				// PC + 8 appears on the result bus as R15
				ctrl.resultSrc = 2'b10;
				ctrl.aluSrcA = 2'b01;
				ctrl.aluSrcB = 2'b10;
			end
			memAdr: ctrl.aluSrcB = 2'b01;
			memRead: ctrl.adrSrc = 1'b1;
			memWriteback: begin
				ctrl.regW = 1'b1;
				ctrl.resultSrc = 2'b01;
			end
			memWrite: begin
				ctrl.memW = 1'b1;
				ctrl.adrSrc = 1'b1;
			end
			executeReg: ctrl.aluOp = 1'b1;
			executeImm: begin
				ctrl.aluSrcB = 2'b01;
				ctrl.aluOp = 1'b1;
			end
			aluWriteback: ctrl.regW = 1'b1;
			branch: begin
				// Target is PC + 8 held in ALU out plus the word offset
				ctrl.branch = 1'b1;
				ctrl.resultSrc = 2'b10;
				ctrl.aluSrcA = 2'b10;
				ctrl.aluSrcB = 2'b01;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/armCore.sv
// Multicycle ARM core
`timescale 1ns/1ps
`default_nettype none

module armCore import armPkg::*; (
	input wire clk,
	input wire reset,
	input wire [dataWidth-1:0] memReadData,
	output logic [dataWidth-1:0] memAdr,
	output logic [dataWidth-1:0] memWriteData,
	output logic memWrite
);

	instrWord_t instr;
	aluFlags_t aluFlags;
	fsmCtrl_t ctrl;
	decodeCtrl_t dec;
	logic [1:0] flagW;
	logic pcs;
	logic pcWrite;
	logic regWrite;

	controlFsm u_controlFsm (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.ctrl(ctrl)
	);

	instrDecode u_instrDecode (
		.instr(instr),
		.ctrl(ctrl),
		.dec(dec),
		.flagW(flagW),
		.pcs(pcs)
	);

	condUnit u_condUnit (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.aluFlags(aluFlags),
		.flagW(flagW),
		.pcs(pcs),
		.ctrl(ctrl),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.memWrite(memWrite)
	);

	datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.dec(dec),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.memReadData(memReadData),
		.memAdr(memAdr),
		.memWriteData(memWriteData),
		.instr(instr),
		.aluFlags(aluFlags)
	);

endmodule

`default_nettype wire

//--- tb/armRefModel.svh
// Instruction-level reference model

`ifndef ARM_REF_MODEL_SVH
`define ARM_REF_MODEL_SVH

typedef struct packed {
	logic [dataWidth-1:0] adr;
	logic [dataWidth-1:0] data;
} storeRec_t;

// Expected stores in program order
storeRec_t expectedStores [$];

logic [dataWidth-1:0] refRegs [15];
logic [dataWidth-1:0] refMem [64];
logic refN;
logic refZ;
logic refC;
logic refV;
logic [31:0] lfsrState;

// Galois step for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] advanceLfsr(input logic [31:0] state);
	if (state[0]) begin
		return (state >> 1) ^ 32'h8020_0003;
	end else begin
		return state >> 1;
	end
endfunction

function automatic logic [31:0] randomBits(input int count);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < count; i++) begin
		bits = {bits[30:0], lfsrState[0]};
		lfsrState = advanceLfsr(lfsrState);
	end
	return bits;
endfunction

function automatic logic [31:0] dataProcWord(input logic [3:0] cond, input logic imm,
	input logic [3:0] cmd, input logic s, input logic [3:0] rn, input logic [3:0] rd,
	input logic [11:0] op2);
	return {cond, opDataProc, imm, cmd, s, rn, rd, op2};
endfunction

// Pre-indexed word access with the offset added
function automatic logic [31:0] memoryWord(input logic [3:0] cond, input logic load,
	input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] offset);
	return {cond, opMemory, 5'b01100, load, rn, rd, offset};
endfunction

function automatic logic [31:0] branchWord(input logic [3:0] cond, input logic [23:0] offset);
	return {cond, opBranch, 2'b10, offset};
endfunction

function automatic logic conditionHolds(input logic [3:0] cond);
	case (cond)
		4'h0: return refZ;
		4'h1: return !refZ;
		4'h2: return refC;
		4'h3: return !refC;
		4'h4: return refN;
		4'h5: return !refN;
		4'h6: return refV;
		4'h7: return !refV;
		4'h8: return refC && !refZ;
		4'h9: return !refC || refZ;
		4'hA: return refN == refV;
		4'hB: return refN != refV;
		4'hC: return !refZ && (refN == refV);
		4'hD: return refZ || (refN != refV);
		default: return 1'b1;
	endcase
endfunction

// R15 reads as the instruction address plus 8
function automatic logic [dataWidth-1:0] operandValue(input logic [3:0] idx,
	input logic [dataWidth-1:0] pc);
	if (idx == 4'hF) begin
		return pc + 8;
	end else begin
		return refRegs[idx];
	end
endfunction

function automatic void runReference();
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] ins;
	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic [dataWidth-1:0] adr;
	logic [dataWidth:0] wide;
	logic finished;
	int steps;
	pc = '0;
	finished = 1'b0;
	steps = 0;
	{refN, refZ, refC, refV} = 4'b0000;
	for (int i = 0; i < 64; i++) begin
		refMem[i] = progImage[i];
	end
	for (int i = 0; i < 15; i++) begin
		refRegs[i] = '0;
	end
	while (!finished && steps < 1000) begin
		ins = refMem[pc[7:2]];
		steps++;
		if (!conditionHolds(ins[31:28])) begin
			pc = pc + 4;
		end else if (ins[27:26] == opDataProc) begin
			a = operandValue(ins[19:16], pc);
			b = ins[25] ? {24'b0, ins[7:0]} : operandValue(ins[3:0], pc);
			case (ins[24:21])
				// Carry out of a subtraction means no borrow
				4'b0010: wide = {a >= b, a - b};
				4'b0000: wide = {1'b0, a & b};
				4'b1100: wide = {1'b0, a | b};
				4'b0001: wide = {1'b0, a ^ b};
				default: wide = {1'b0, a} + {1'b0, b};
			endcase
			if (ins[20]) begin
				refN = wide[31];
				refZ = (wide[31:0] == '0);
				// Carry and overflow belong to ADD and SUB only
				if (ins[24:21] == 4'b0100) begin
					refC = wide[32];
					refV = (a[31] == b[31]) && (wide[31] != a[31]);
				end else if (ins[24:21] == 4'b0010) begin
					refC = wide[32];
					refV = (a[31] != b[31]) && (wide[31] != a[31]);
				end
			end
			if (ins[15:12] == 4'hF) begin
				pc = wide[31:0];
			end else begin
				refRegs[ins[15:12]] = wide[31:0];
				pc = pc + 4;
			end
		end else if (ins[27:26] == opMemory) begin
			adr = operandValue(ins[19:16], pc) + ins[11:0];
			if (ins[20]) begin
				refRegs[ins[15:12]] = refMem[adr[7:2]];
			end else begin
				expectedStores.push_back({adr, operandValue(ins[15:12], pc)});
				refMem[adr[7:2]] = operandValue(ins[15:12], pc);
				finished = (adr == doneAdr);
			end
			pc = pc + 4;
		end else if (ins[27:26] == opBranch) begin
			pc = pc + 8 + {{6{ins[23]}}, ins[23:0], 2'b00};
		end else begin
			pc = pc + 4;
		end
	end
	if (!finished) begin
		errorCount++;
		$display("Reference model never reached the done store within 1000 instructions");
	end
endfunction

`endif

//--- tb/armCoreTb.sv
// ARM core testbench
`timescale 1ns/1ps
`default_nettype none

module armCoreTb import armPkg::*; ();

	localparam int memWords = 64;
	localparam int tableWord = 53;
	localparam int timeoutCycles = 2000;
	localparam logic [31:0] lfsrSeed = 32'ha85;
	localparam logic [dataWidth-1:0] storeBase = 32'h0000_00E0;
	localparam logic [dataWidth-1:0] doneAdr = 32'h0000_00FC;

	localparam logic [3:0] condEq = 4'h0;
	localparam logic [3:0] condNe = 4'h1;
	localparam logic [3:0] condAlways = 4'hE;

	localparam logic [3:0] cmdAdd = 4'b0100;
	localparam logic [3:0] cmdSub = 4'b0010;
	localparam logic [3:0] cmdAnd = 4'b0000;
	localparam logic [3:0] cmdOrr = 4'b1100;
	localparam logic [3:0] cmdEor = 4'b0001;
	// ADD first, EOR last
	localparam logic [19:0] cmdList = {cmdEor, cmdOrr, cmdAnd, cmdSub, cmdAdd};

	logic clk;
	logic reset;
	logic [dataWidth-1:0] memReadData;
	logic [dataWidth-1:0] memAdr;
	logic [dataWidth-1:0] memWriteData;
	logic memWrite;
	logic [dataWidth-1:0] mem [memWords];
	logic [dataWidth-1:0] progImage [memWords];
	int errorCount;
	int storeCount;
	int progIdx;
	logic doneSeen;

	`include "armRefModel.svh"

	storeRec_t popped;

	armCore u_armCore (
		.clk(clk),
		.reset(reset),
		.memReadData(memReadData),
		.memAdr(memAdr),
		.memWriteData(memWriteData),
		.memWrite(memWrite)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// Memory answers reads in the same cycle
	assign memReadData = mem[memAdr[7:2]];

	always @(posedge clk) begin
		if (memWrite === 1'b1) begin
			mem[memAdr[7:2]] <= memWriteData;
		end
	end

	task automatic checkValue(input string what, input logic [dataWidth-1:0] actual,
		input logic [dataWidth-1:0] expected);
		if (actual !== expected) begin
			errorCount++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Every store is matched against the next reference store
	always @(posedge clk) begin
		if (memWrite === 1'b1) begin
			if (expectedStores.size() == 0) begin
				errorCount++;
				$display("Store of %h to %h at %0t ns has no matching reference store",
					memWriteData, memAdr, $time);
			end else begin
				popped = expectedStores.pop_front();
				checkValue("store address", memAdr, popped.adr);
				checkValue("store data", memWriteData, popped.data);
			end
			storeCount++;
			if (memAdr == doneAdr) begin
				doneSeen = 1'b1;
			end
		end
	end

	task automatic placeWord(input logic [dataWidth-1:0] word);
		progImage[progIdx] = word;
		progIdx++;
	endtask

	task automatic buildProgram();
		logic [3:0] rm;
		int cnt;
		int loopIdx;
		for (int i = 0; i < memWords; i++) begin
			progImage[i] = 32'hA5A5_0000 | i;
		end
		progIdx = 0;
		// r1 to r3 from the random table, PC-relative
		for (int r = 1; r <= 3; r++) begin
			placeWord(memoryWord(condAlways, 1'b1, 4'hF, r, 4 * (tableWord + r - 1 - progIdx - 2)));
		end
		placeWord(dataProcWord(condAlways, 1'b0, cmdEor, 1'b0, 4'd1, 4'd0, 12'd1));
		placeWord(dataProcWord(condAlways, 1'b1, cmdAdd, 1'b0, 4'd0, 4'd12, storeBase[11:0]));

		// Register and immediate forms of each operation
		for (int k = 0; k < 5; k++) begin
			rm = 4'd2 + randomBits(1);
			placeWord(dataProcWord(condAlways, 1'b0, cmdList[k*4 +: 4], 1'b0, 4'd1, 4'd4,
				{8'd0, rm}));
			placeWord(memoryWord(condAlways, 1'b0, 4'd12, 4'd4, ((2 * k) % 7) * 4));
			placeWord(dataProcWord(condAlways, 1'b1, cmdList[k*4 +: 4], 1'b0, rm, 4'd5,
				randomBits(8)));
			placeWord(memoryWord(condAlways, 1'b0, 4'd12, 4'd5, ((2 * k + 1) % 7) * 4));
		end

		// Reload stored words and combine them
		placeWord(memoryWord(condAlways, 1'b1, 4'd12, 4'd6, 12'd0));
		placeWord(memoryWord(condAlways, 1'b1, 4'd12, 4'd7, 12'd4));
		placeWord(dataProcWord(condAlways, 1'b0, cmdSub, 1'b0, 4'd6, 4'd8, 12'd7));
		placeWord(memoryWord(condAlways, 1'b0, 4'd12, 4'd8, 12'd8));

		// Equal operands give Z and C, then ADDS of random operands
		placeWord(dataProcWord(condAlways, 1'b0, cmdSub, 1'b1, 4'd1, 4'd9, 12'd1));
		for (int c = 0; c < 15; c++) begin
			if (c == 8) begin
				placeWord(dataProcWord(condAlways, 1'b0, cmdAdd, 1'b1, 4'd1, 4'd9, 12'd2));
			end
			placeWord(memoryWord(c, 1'b0, 4'd12, 4'd1 + c % 3, (c % 7) * 4));
		end

		// Counted loop
		cnt = 2 + randomBits(2);
		placeWord(dataProcWord(condAlways, 1'b1, cmdAdd, 1'b0, 4'd0, 4'd10, cnt));
		loopIdx = progIdx;
		placeWord(dataProcWord(condAlways, 1'b1, cmdSub, 1'b1, 4'd10, 4'd10, 12'd1));
		placeWord(memoryWord(condAlways, 1'b0, 4'd12, 4'd10, 12'd16));
		placeWord(branchWord(condNe, loopIdx - progIdx - 2));
		// Offset zero lands two words ahead, over the next store
		placeWord(branchWord(condEq, 24'd0));
		placeWord(memoryWord(condAlways, 1'b0, 4'd12, 4'd1, 12'd20));
		placeWord(memoryWord(condAlways, 1'b0, 4'd12, 4'd9, doneAdr - storeBase));

		for (int t = 0; t < 3; t++) begin
			progImage[tableWord + t] = randomBits(32);
		end
	endtask

	task automatic waitForDone();
		int cycles;
		cycles = 0;
		while (!doneSeen && cycles < timeoutCycles) begin
			@(negedge clk);
			cycles++;
		end
		if (!doneSeen) begin
			errorCount++;
			$display("Timeout: no store to the done address after %0d cycles", timeoutCycles);
		end
	endtask

	initial begin
		reset = 1'b1;
		errorCount = 0;
		storeCount = 0;
		doneSeen = 1'b0;
		lfsrState = lfsrSeed;
		buildProgram();
		runReference();
		for (int i = 0; i < memWords; i++) begin
			mem[i] = progImage[i];
		end
		repeat (16) begin
			@(negedge clk);
			checkValue("memWrite during reset", memWrite, '0);
			checkValue("memAdr during reset", memAdr, '0);
		end
		reset = 1'b0;
		#1;
		checkValue("memWrite after reset", memWrite, '0);
		checkValue("memAdr after reset", memAdr, '0);
		waitForDone();
		if (expectedStores.size() != 0) begin
			errorCount++;
			$display("%0d reference stores never reached the memory port",
				expectedStores.size());
		end
		$display("Errors: %0d, stores compared: %0d", errorCount, storeCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- armCore.f
+incdir+tb
rtl/armPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/datapath.sv
rtl/condUnit.sv
rtl/instrDecode.sv
rtl/controlFsm.sv
rtl/armCore.sv
tb/armCoreTb.sv
